//--- design/calc_isa_pkg.sv
`default_nettype none

package calc_isa_pkg;

  // Datapath widths
  localparam int OPND_W = 16;
  localparam int SEQ_W  = 8;

  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SHL = 3'd5,
    OP_SHR = 3'd6,
    OP_MUL = 3'd7
  } opcode_t;

  // Host command word, 35 bits
  typedef struct packed {
    opcode_t             opcode;
    logic [OPND_W-1:0]   a;
    logic [OPND_W-1:0]   b;
  } cmd_t;

  // Result word returned to the host, 26 bits
  typedef struct packed {
    logic [SEQ_W-1:0]    seq;
    logic [OPND_W-1:0]   value;
    logic                carry;
    logic                zero;
  } result_t;

endpackage

`default_nettype wire

//--- design/calc_cfg_pkg.sv
`default_nettype none

package calc_cfg_pkg;

  // Default queue depths
  localparam int CMD_DEPTH_DEF = 8;
  localparam int RES_DEPTH_DEF = 8;

  // Registers between command pop and result push
  // (decode, execute, pack)
  localparam int PIPE_INFLIGHT = 3;

endpackage

`default_nettype wire

//--- design/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type payload_t        = logic [31:0],
  parameter int  DEPTH            = 8,
  parameter bit  FWFT_MODE        = 1'b0,
  parameter int  ALMOST_FULL_THRESH  = DEPTH - 1,
  parameter int  ALMOST_EMPTY_THRESH = 1
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush,
  input  logic                   push,
  input  payload_t               data_in,
  output logic                   full,
  output logic                   almost_full,
  output logic                   overflow,
  input  logic                   pop,
  output payload_t               data_out,
  output logic                   empty,
  output logic                   almost_empty,
  output logic                   underflow,
  output logic [$clog2(DEPTH):0] level,
  output logic [$clog2(DEPTH):0] max_level
);

  localparam int AW = $clog2(DEPTH);
  localparam int LW = AW + 1;
  localparam logic [AW-1:0] PTR_MAX = AW'(DEPTH - 1);

  payload_t        mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [LW-1:0]   count;
  logic [LW-1:0]   next_count;
  logic            push_ok;
  logic            pop_ok;

  // Accepted transfers only
  assign push_ok = push && !full;
  assign pop_ok  = pop && !empty;

  assign full         = (count == LW'(DEPTH));
  assign empty        = (count == '0);
  assign almost_full  = (count >= LW'(ALMOST_FULL_THRESH));
  assign almost_empty = (count <= LW'(ALMOST_EMPTY_THRESH));
  assign level        = count;

  always_comb begin
    case ({push_ok, pop_ok})
      2'b10:   next_count = count + 1'b1;
      2'b01:   next_count = count - 1'b1;
      default: next_count = count;
    endcase
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= data_in;
    end
  end

  // Pointers, occupancy and sticky error flags
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      max_level <= '0;
      overflow  <= 1'b0;
      underflow <= 1'b0;
    end else if (flush) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      max_level <= '0;
      overflow  <= 1'b0;
      underflow <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == PTR_MAX) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == PTR_MAX) ? '0 : rd_ptr + 1'b1;
      end
      if (push && full) begin
        overflow <= 1'b1;
      end
      if (pop && empty) begin
        underflow <= 1'b1;
      end
      count <= next_count;
      // High-water mark
      if (next_count > max_level) begin
        max_level <= next_count;
      end
    end
  end

  generate
    if (FWFT_MODE) begin : gen_fwft
      // Head word visible before the pop
      assign data_out = mem[rd_ptr];
    end else begin : gen_registered
      always_ff @(posedge clk) begin
        if (pop_ok) begin
          data_out <= mem[rd_ptr];
        end
      end
    end
  endgenerate

endmodule

`default_nettype wire

//--- design/cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decode import calc_isa_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush,
  input  cmd_t              cmd,
  input  logic              cmd_empty,
  input  logic              res_almost_full,
  output logic              cmd_pop,
  output logic              dec_valid,
  output logic              op_arith,
  output logic              op_logic,
  output logic              op_shift,
  output logic              op_mul,
  output logic              sub_sel,
  output logic [1:0]        logic_sel,
  output logic              shift_left,
  output logic [3:0]        shamt,
  output logic [OPND_W-1:0] opnd_a,
  output logic [OPND_W-1:0] opnd_b
);

  logic       nxt_arith;
  logic       nxt_logic;
  logic       nxt_shift;
  logic       nxt_mul;
  logic       nxt_sub;
  logic [1:0] nxt_logic_sel;
  logic       nxt_left;

  // Stall while the result queue cannot absorb what is in flight
  assign cmd_pop = !cmd_empty && !res_almost_full && !flush;

  always_comb begin
    nxt_arith     = 1'b0;
    nxt_logic     = 1'b0;
    nxt_shift     = 1'b0;
    nxt_mul       = 1'b0;
    nxt_sub       = 1'b0;
    nxt_logic_sel = 2'b00;
    nxt_left      = 1'b0;
    case (cmd.opcode)
      OP_ADD: nxt_arith = 1'b1;
      OP_SUB: begin
        nxt_arith = 1'b1;
        nxt_sub   = 1'b1;
      end
      OP_AND: nxt_logic = 1'b1;
      OP_OR: begin
        nxt_logic     = 1'b1;
        nxt_logic_sel = 2'b01;
      end
      OP_XOR: begin
        nxt_logic     = 1'b1;
        nxt_logic_sel = 2'b10;
      end
      OP_SHL: begin
        nxt_shift = 1'b1;
        nxt_left  = 1'b1;
      end
      OP_SHR:  nxt_shift = 1'b1;
      default: nxt_mul   = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else if (flush) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= cmd_pop;
    end
  end

  // Decoded fields, qualified by dec_valid downstream
  always_ff @(posedge clk) begin
    if (cmd_pop) begin
      op_arith   <= nxt_arith;
      op_logic   <= nxt_logic;
      op_shift   <= nxt_shift;
      op_mul     <= nxt_mul;
      sub_sel    <= nxt_sub;
      logic_sel  <= nxt_logic_sel;
      shift_left <= nxt_left;
      shamt      <= cmd.b[3:0];
      opnd_a     <= cmd.a;
      opnd_b     <= cmd.b;
    end
  end

endmodule

`default_nettype wire

//--- design/alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module alu_execute import calc_isa_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush,
  input  logic              dec_valid,
  input  logic              op_arith,
  input  logic              op_logic,
  input  logic              op_shift,
  input  logic              op_mul,
  input  logic              sub_sel,
  input  logic [1:0]        logic_sel,
  input  logic              shift_left,
  input  logic [3:0]        shamt,
  input  logic [OPND_W-1:0] opnd_a,
  input  logic [OPND_W-1:0] opnd_b,
  output logic              ex_valid,
  output logic [OPND_W-1:0] ex_value,
  output logic              ex_carry
);

  logic [OPND_W:0]     arith_res;
  logic [OPND_W:0]     shl_res;
  logic [OPND_W:0]     shr_res;
  logic [2*OPND_W-1:0] product;
  logic [OPND_W-1:0]   logic_res;
  logic [OPND_W-1:0]   nxt_value;
  logic                nxt_carry;

  // Bit 16 is carry on add and borrow on subtract
  assign arith_res = sub_sel ? ({1'b0, opnd_a} - {1'b0, opnd_b})
                             : ({1'b0, opnd_a} + {1'b0, opnd_b});

  // Extra bit catches the last bit shifted out, zero for shamt 0
  assign shl_res = {1'b0, opnd_a} << shamt;
  assign shr_res = {opnd_a, 1'b0} >> shamt;

  assign product = opnd_a * opnd_b;

  always_comb begin
    case (logic_sel)
      2'b00:   logic_res = opnd_a & opnd_b;
      2'b01:   logic_res = opnd_a | opnd_b;
      default: logic_res = opnd_a ^ opnd_b;
    endcase
  end

  always_comb begin
    nxt_value = logic_res;
    nxt_carry = 1'b0;
    if (op_arith) begin
      nxt_value = arith_res[OPND_W-1:0];
      nxt_carry = arith_res[OPND_W];
    end else if (op_shift && shift_left) begin
      nxt_value = shl_res[OPND_W-1:0];
      nxt_carry = shl_res[OPND_W];
    end else if (op_shift) begin
      nxt_value = shr_res[OPND_W:1];
      nxt_carry = shr_res[0];
    end else if (op_mul) begin
      nxt_value = product[OPND_W-1:0];
      nxt_carry = |product[2*OPND_W-1:OPND_W];
    end else if (!op_logic) begin
      nxt_value = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
    end else if (flush) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      ex_value <= nxt_value;
      ex_carry <= nxt_carry;
    end
  end

endmodule

`default_nettype wire

//--- design/result_pack.sv
`timescale 1ns/1ps
`default_nettype none

module result_pack import calc_isa_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush,
  input  logic              ex_valid,
  input  logic [OPND_W-1:0] ex_value,
  input  logic              ex_carry,
  output logic              res_push,
  output result_t           res_word
);

  logic [SEQ_W-1:0] seq_cnt;

  // Sequence counter wraps naturally at 8 bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seq_cnt  <= '0;
      res_push <= 1'b0;
    end else if (flush) begin
      seq_cnt  <= '0;
      res_push <= 1'b0;
    end else begin
      res_push <= ex_valid;
      if (ex_valid) begin
        seq_cnt <= seq_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      res_word.seq   <= seq_cnt;
      res_word.value <= ex_value;
      res_word.carry <= ex_carry;
      res_word.zero  <= (ex_value == '0);
    end
  end

endmodule

`default_nettype wire

//--- design/calc_top.sv
`timescale 1ns/1ps
`default_nettype none

module calc_top import calc_isa_pkg::*, calc_cfg_pkg::*; #(
  parameter int CMD_DEPTH = CMD_DEPTH_DEF,
  parameter int RES_DEPTH = RES_DEPTH_DEF
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       flush,
  input  logic                       cmd_push,
  input  cmd_t                       cmd_data,
  output logic                       cmd_full,
  output logic                       cmd_overflow,
  input  logic                       res_pop,
  output result_t                    res_data,
  output logic                       res_empty,
  output logic                       res_underflow,
  output logic [$clog2(RES_DEPTH):0] res_level,
  output logic [$clog2(RES_DEPTH):0] res_max_level
);

  cmd_t              cmd_head;
  logic              cmd_empty;
  logic              cmd_pop;
  logic              res_almost_full;
  logic              dec_valid;
  logic              op_arith;
  logic              op_logic;
  logic              op_shift;
  logic              op_mul;
  logic              sub_sel;
  logic [1:0]        logic_sel;
  logic              shift_left;
  logic [3:0]        shamt;
  logic [OPND_W-1:0] opnd_a;
  logic [OPND_W-1:0] opnd_b;
  logic              ex_valid;
  logic [OPND_W-1:0] ex_value;
  logic              ex_carry;
  logic              res_push;
  result_t           res_word;

  // Command queue, head visible to decode
  sync_fifo #(
    .payload_t          (cmd_t),
    .DEPTH              (CMD_DEPTH),
    .FWFT_MODE          (1'b1),
    .ALMOST_FULL_THRESH (CMD_DEPTH - 1),
    .ALMOST_EMPTY_THRESH(1)
  ) u_cmd_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .push        (cmd_push),
    .data_in     (cmd_data),
    .full        (cmd_full),
    .almost_full (),
    .overflow    (cmd_overflow),
    .pop         (cmd_pop),
    .data_out    (cmd_head),
    .empty       (cmd_empty),
    .almost_empty(),
    .underflow   (),
    .level       (),
    .max_level   ()
  );

  cmd_decode u_decode (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .cmd            (cmd_head),
    .cmd_empty      (cmd_empty),
    .res_almost_full(res_almost_full),
    .cmd_pop        (cmd_pop),
    .dec_valid      (dec_valid),
    .op_arith       (op_arith),
    .op_logic       (op_logic),
    .op_shift       (op_shift),
    .op_mul         (op_mul),
    .sub_sel        (sub_sel),
    .logic_sel      (logic_sel),
    .shift_left     (shift_left),
    .shamt          (shamt),
    .opnd_a         (opnd_a),
    .opnd_b         (opnd_b)
  );

  alu_execute u_execute (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .dec_valid (dec_valid),
    .op_arith  (op_arith),
    .op_logic  (op_logic),
    .op_shift  (op_shift),
    .op_mul    (op_mul),
    .sub_sel   (sub_sel),
    .logic_sel (logic_sel),
    .shift_left(shift_left),
    .shamt     (shamt),
    .opnd_a    (opnd_a),
    .opnd_b    (opnd_b),
    .ex_valid  (ex_valid),
    .ex_value  (ex_value),
    .ex_carry  (ex_carry)
  );

  result_pack u_pack (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush   (flush),
    .ex_valid(ex_valid),
    .ex_value(ex_value),
    .ex_carry(ex_carry),
    .res_push(res_push),
    .res_word(res_word)
  );

  // Early almost_full leaves room for every word still in the pipeline
  sync_fifo #(
    .payload_t          (result_t),
    .DEPTH              (RES_DEPTH),
    .FWFT_MODE          (1'b0),
    .ALMOST_FULL_THRESH (RES_DEPTH - PIPE_INFLIGHT),
    .ALMOST_EMPTY_THRESH(1)
  ) u_res_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .push        (res_push),
    .data_in     (res_word),
    .full        (),
    .almost_full (res_almost_full),
    .overflow    (),
    .pop         (res_pop),
    .data_out    (res_data),
    .empty       (res_empty),
    .almost_empty(),
    .underflow   (res_underflow),
    .level       (res_level),
    .max_level   (res_max_level)
  );

endmodule

`default_nettype wire

//--- testbench/tb_calc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_calc_top import calc_isa_pkg::*, calc_cfg_pkg::*; ();

  localparam int CMD_DEPTH   = CMD_DEPTH_DEF;
  localparam int RES_DEPTH   = RES_DEPTH_DEF;
  localparam int LVL_W       = $clog2(RES_DEPTH) + 1;
  // Result side never drops below RES_DEPTH - PIPE_INFLIGHT - 1 while decode has work,
  // so this many outstanding commands always fit in the command queue
  localparam int PUSH_BOUND  = CMD_DEPTH + RES_DEPTH - PIPE_INFLIGHT - 1;
  localparam int RAND_CYCLES = 1200;
  // Random phase and its drain, then the directed phases
  localparam int CYCLE_LIMIT = 2 * RAND_CYCLES + 1600;

  logic             clk;
  logic             rst_n;
  logic             flush;
  logic             cmd_push;
  cmd_t             cmd_data;
  logic             cmd_full;
  logic             cmd_overflow;
  logic             res_pop;
  result_t          res_data;
  logic             res_empty;
  logic             res_underflow;
  logic [LVL_W-1:0] res_level;
  logic [LVL_W-1:0] res_max_level;

  result_t          exp_q[$];
  logic [SEQ_W-1:0] seq_model;
  logic [31:0]      rng_state;
  logic             pop_pend;
  int               cycle_cnt;

  calc_top #(
    .CMD_DEPTH(CMD_DEPTH),
    .RES_DEPTH(RES_DEPTH)
  ) DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .cmd_push     (cmd_push),
    .cmd_data     (cmd_data),
    .cmd_full     (cmd_full),
    .cmd_overflow (cmd_overflow),
    .res_pop      (res_pop),
    .res_data     (res_data),
    .res_empty    (res_empty),
    .res_underflow(res_underflow),
    .res_level    (res_level),
    .res_max_level(res_max_level)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      fail_run("Timeout: the run did not finish within the cycle limit");
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    assert (actual === expected) else begin
      fail_run($sformatf("CHECK FAILED at %0t: %s expected %0h, actual %0h",
                         $time, name, expected, actual));
    end
  endtask

  function automatic logic [31:0] rand_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Reference ALU, straight from the opcode rules
  function automatic result_t expect_result(input cmd_t c, input logic [SEQ_W-1:0] seq);
    result_t     r;
    logic [16:0] wide;
    logic [31:0] prod;
    int          s;
    r       = '0;
    r.seq   = seq;
    s       = int'(c.b[3:0]);
    case (c.opcode)
      OP_ADD: begin
        wide    = 17'(c.a) + 17'(c.b);
        r.value = wide[15:0];
        r.carry = wide[16];
      end
      OP_SUB: begin
        r.value = c.a - c.b;
        r.carry = (c.a < c.b);
      end
      OP_AND: r.value = c.a & c.b;
      OP_OR:  r.value = c.a | c.b;
      OP_XOR: r.value = c.a ^ c.b;
      OP_SHL: begin
        r.value = c.a << s;
        if (s != 0) begin
          r.carry = c.a[16 - s];
        end
      end
      OP_SHR: begin
        r.value = c.a >> s;
        if (s != 0) begin
          r.carry = c.a[s - 1];
        end
      end
      default: begin
        prod    = 32'(c.a) * 32'(c.b);
        r.value = prod[15:0];
        r.carry = (prod[31:16] != 16'd0);
      end
    endcase
    r.zero = (r.value == 16'd0);
    return r;
  endfunction

  function automatic cmd_t make_cmd(input opcode_t op, input logic [15:0] a,
                                    input logic [15:0] b);
    cmd_t c;
    c.opcode = op;
    c.a      = a;
    c.b      = b;
    return c;
  endfunction

  function automatic cmd_t random_cmd();
    cmd_t        c;
    logic [31:0] r1;
    logic [31:0] r2;
    r1       = rand_next();
    r2       = rand_next();
    c.opcode = opcode_t'(r1[2:0]);
    c.a      = r1[31:16];
    c.b      = r2[31:16];
    // Zero operand now and then to reach the zero flag
    if (r2[3:0] == 4'd0) begin
      c.a = '0;
    end
    return c;
  endfunction

  // Next edge, then check the word popped in the previous cycle
  task automatic tick();
    result_t expv;
    @(posedge clk);
    #2;
    if (pop_pend) begin
      if (exp_q.size() == 0) begin
        fail_run("A result was popped while the model expected none");
      end
      expv = exp_q.pop_front();
      check_eq("res_data.seq", 32'(res_data.seq), 32'(expv.seq));
      check_eq("res_data.value", 32'(res_data.value), 32'(expv.value));
      check_eq("res_data.carry", 32'(res_data.carry), 32'(expv.carry));
      check_eq("res_data.zero", 32'(res_data.zero), 32'(expv.zero));
      pop_pend = 1'b0;
    end
    cmd_push = 1'b0;
    res_pop  = 1'b0;
    flush    = 1'b0;
  endtask

  task automatic queue_cmd(input cmd_t c);
    cmd_push = 1'b1;
    cmd_data = c;
    exp_q.push_back(expect_result(c, seq_model));
    seq_model = seq_model + 1'b1;
  endtask

  task automatic start_pop();
    if (!res_empty) begin
      res_pop  = 1'b1;
      pop_pend = 1'b1;
    end
  endtask

  // Pops alongside, pushes once the outstanding count allows
  task automatic send_cmd(input cmd_t c);
    bit sent;
    sent = 1'b0;
    while (!sent) begin
      tick();
      start_pop();
      if (exp_q.size() < PUSH_BOUND) begin
        queue_cmd(c);
        sent = 1'b1;
      end
    end
  endtask

  task automatic drain_results();
    while (exp_q.size() > 0) begin
      tick();
      if (exp_q.size() > 0) begin
        start_pop();
      end
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [3:0]  pop_rate;
    clk       = 1'b0;
    rst_n     = 1'b0;
    flush     = 1'b0;
    cmd_push  = 1'b0;
    cmd_data  = '0;
    res_pop   = 1'b0;
    pop_pend  = 1'b0;
    seq_model = '0;
    rng_state = 32'hfb3a7ec0;
    cycle_cnt = 0;
    repeat (4) @(posedge clk);
    #2;
    check_eq("cmd_full", 32'(cmd_full), 32'd0);
    check_eq("cmd_overflow", 32'(cmd_overflow), 32'd0);
    check_eq("res_empty", 32'(res_empty), 32'd1);
    check_eq("res_underflow", 32'(res_underflow), 32'd0);
    check_eq("res_level", 32'(res_level), 32'd0);
    check_eq("res_max_level", 32'(res_max_level), 32'd0);
    rst_n = 1'b1;

    // Mixed traffic, pop rate alternating between slow and fast windows
    for (int i = 0; i < RAND_CYCLES; i++) begin
      tick();
      r        = rand_next();
      pop_rate = ((i / 200) % 2 == 1) ? 4'd3 : 4'd12;
      if (r[3:0] < pop_rate) begin
        start_pop();
      end
      if (r[7:4] < 4'd9 && exp_q.size() < PUSH_BOUND) begin
        queue_cmd(random_cmd());
      end
    end
    drain_results();
    check_eq("cmd_overflow", 32'(cmd_overflow), 32'd0);
    check_eq("res_underflow", 32'(res_underflow), 32'd0);

    // Corner cases per opcode
    send_cmd(make_cmd(OP_ADD, 16'hffff, 16'h0001));
    send_cmd(make_cmd(OP_ADD, 16'h1234, 16'h4321));
    send_cmd(make_cmd(OP_SUB, 16'h0003, 16'h0005));
    send_cmd(make_cmd(OP_SUB, 16'h5555, 16'h5555));
    send_cmd(make_cmd(OP_AND, 16'hf0f0, 16'h0f0f));
    send_cmd(make_cmd(OP_OR,  16'ha000, 16'h000a));
    send_cmd(make_cmd(OP_XOR, 16'hbeef, 16'hbeef));
    send_cmd(make_cmd(OP_SHL, 16'h8001, 16'h0010));
    send_cmd(make_cmd(OP_SHL, 16'h0003, 16'h000f));
    send_cmd(make_cmd(OP_SHL, 16'h0001, 16'h000f));
    send_cmd(make_cmd(OP_SHR, 16'h8001, 16'h0000));
    send_cmd(make_cmd(OP_SHR, 16'hc000, 16'h00ff));
    send_cmd(make_cmd(OP_SHR, 16'h8000, 16'h000f));
    send_cmd(make_cmd(OP_MUL, 16'hffff, 16'hffff));
    send_cmd(make_cmd(OP_MUL, 16'h00ff, 16'h0100));
    send_cmd(make_cmd(OP_MUL, 16'h0100, 16'h0100));
    drain_results();

    // Back-pressure with the host not popping
    for (int i = 0; i < CMD_DEPTH + RES_DEPTH; i++) begin
      tick();
      queue_cmd(random_cmd());
    end
    repeat (20) tick();
    check_eq("cmd_full", 32'(cmd_full), 32'd1);
    check_eq("cmd_overflow", 32'(cmd_overflow), 32'd0);
    check_eq("res_level", 32'(res_level), 32'(RES_DEPTH));
    check_eq("res_max_level", 32'(res_max_level), 32'(RES_DEPTH));
    // One push too many, dropped by the DUT
    tick();
    cmd_push = 1'b1;
    cmd_data = random_cmd();
    tick();
    check_eq("cmd_overflow", 32'(cmd_overflow), 32'd1);
    drain_results();

    // Pop from an empty result queue
    tick();
    check_eq("res_empty", 32'(res_empty), 32'd1);
    res_pop = 1'b1;
    tick();
    check_eq("res_underflow", 32'(res_underflow), 32'd1);
    repeat (4) send_cmd(random_cmd());
    drain_results();

    // Results left in the queue are discarded by flush
    for (int i = 0; i < 3; i++) begin
      tick();
      cmd_push = 1'b1;
      cmd_data = random_cmd();
    end
    repeat (8) tick();
    check_eq("res_level", 32'(res_level), 32'd3);
    flush = 1'b1;
    tick();
    check_eq("cmd_overflow", 32'(cmd_overflow), 32'd0);
    check_eq("res_underflow", 32'(res_underflow), 32'd0);
    check_eq("res_level", 32'(res_level), 32'd0);
    check_eq("res_max_level", 32'(res_max_level), 32'd0);
    check_eq("res_empty", 32'(res_empty), 32'd1);
    seq_model = '0;
    send_cmd(make_cmd(OP_ADD, 16'h0007, 16'h0009));
    send_cmd(random_cmd());
    drain_results();

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
design/calc_isa_pkg.sv
design/calc_cfg_pkg.sv
design/sync_fifo.sv
design/cmd_decode.sv
design/alu_execute.sv
design/result_pack.sv
design/calc_top.sv
testbench/tb_calc_top.sv

//--- Makefile
TOP := tb_calc_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
